// File: verilog/tmu_defs.svh
// Widths, register offsets and divider step count for the TMU vertical interpolator
`ifndef TMU_DEFS_SVH
`define TMU_DEFS_SVH

// Datapath widths
`define TMU_COORD_W     18      // 1 sign, 11 integer, 6 fraction
`define TMU_ROW_W       11
`define TMU_DIV_STEPS   17      // One quotient bit per cycle

// AXI4-Lite
`define TMU_AXI_ADDR_W  8
`define TMU_AXI_DATA_W  32
`define TMU_AXI_OKAY    2'b00

// Register map
`define TMU_REG_CTRL    8'h00   // Bit 0 start/busy, bit 1 irq pending
`define TMU_REG_SQUAREH 8'h04
`define TMU_REG_AX      8'h08
`define TMU_REG_AY      8'h0C
`define TMU_REG_BX      8'h10
`define TMU_REG_BY      8'h14
`define TMU_REG_CX      8'h18
`define TMU_REG_CY      8'h1C
`define TMU_REG_DX      8'h20
`define TMU_REG_DY      8'h24

`endif

// File: verilog/tmu_pkg.sv
// Point, edge configuration and span types plus the FSM state enums of the TMU
`default_nettype none

`include "tmu_defs.svh"

package tmu_pkg;

	// ####################
	// Data types

	// Texture coordinate pair, signed fixed point
	typedef struct packed {
		logic signed [`TMU_COORD_W-1:0] x;
		logic signed [`TMU_COORD_W-1:0] y;
	} tmu_point_t;

	// One mesh edge, walked from start_pt toward end_pt
	typedef struct packed {
		tmu_point_t start_pt;
		tmu_point_t end_pt;
	} tmu_edge_cfg_t;

	typedef struct packed {
		logic [`TMU_ROW_W-1:0] row;
		tmu_point_t            ts;    // Left end of the span
		tmu_point_t            te;    // Right end of the span
	} tmu_span_t;

	// ####################
	// FSM states

	typedef enum logic [1:0] {
		EDGE_IDLE,
		EDGE_DIVIDE,
		EDGE_STEP
	} edge_state_e;

	typedef enum logic [1:0] {
		JOIN_IDLE,
		JOIN_WAIT,
		JOIN_RUN
	} join_state_e;

	typedef enum logic {
		AXIL_IDLE,
		AXIL_RESP
	} axil_state_e;

endpackage

`default_nettype wire

// File: verilog/tmu_csr.sv
// AXI4-Lite control registers for corner points, square height, start pulse and interrupt
`timescale 1ns/1ps
`default_nettype none

`include "tmu_defs.svh"

module tmu_csr (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire [`TMU_AXI_ADDR_W-1:0]  s_axil_awaddr_i,
	input  wire                        s_axil_awvalid_i,
	output logic                       s_axil_awready_o,
	input  wire [`TMU_AXI_DATA_W-1:0]  s_axil_wdata_i,
	input  wire                        s_axil_wvalid_i,
	output logic                       s_axil_wready_o,
	output logic [1:0]                 s_axil_bresp_o,
	output logic                       s_axil_bvalid_o,
	input  wire                        s_axil_bready_i,
	input  wire [`TMU_AXI_ADDR_W-1:0]  s_axil_araddr_i,
	input  wire                        s_axil_arvalid_i,
	output logic                       s_axil_arready_o,
	output logic [`TMU_AXI_DATA_W-1:0] s_axil_rdata_o,
	output logic [1:0]                 s_axil_rresp_o,
	output logic                       s_axil_rvalid_o,
	input  wire                        s_axil_rready_i,
	input  wire                        busy_i,
	input  wire                        done_i,
	output logic                       start_o,
	output tmu_pkg::tmu_edge_cfg_t     left_cfg_o,
	output tmu_pkg::tmu_edge_cfg_t     right_cfg_o,
	output logic [`TMU_ROW_W-1:0]      squareh_o,
	output logic                       irq_o
);

	localparam int CW = `TMU_COORD_W;
	localparam int DW = `TMU_AXI_DATA_W;

	tmu_pkg::axil_state_e wr_state, rd_state;
	tmu_pkg::tmu_point_t  pa, pb, pc, pd;    // Corner points
	logic [`TMU_ROW_W-1:0] squareh;
	logic                  wr_fire, rd_fire, wr_ctrl;
	logic                  start_req, irq_pending, busy_bit;
	logic [DW-1:0]         rd_mux;

	function automatic logic [DW-1:0] sext(input logic [CW-1:0] v);
		return {{(DW-CW){v[CW-1]}}, v};
	endfunction

	// ####################
	// Handshakes

	assign wr_fire = (wr_state == tmu_pkg::AXIL_IDLE) && s_axil_awvalid_i && s_axil_wvalid_i;
	assign rd_fire = (rd_state == tmu_pkg::AXIL_IDLE) && s_axil_arvalid_i;
	assign s_axil_awready_o = wr_fire;     // Address and data taken together
	assign s_axil_wready_o  = wr_fire;
	assign s_axil_arready_o = rd_fire;
	assign s_axil_bvalid_o  = (wr_state == tmu_pkg::AXIL_RESP);
	assign s_axil_rvalid_o  = (rd_state == tmu_pkg::AXIL_RESP);
	assign s_axil_bresp_o   = `TMU_AXI_OKAY;
	assign s_axil_rresp_o   = `TMU_AXI_OKAY;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_state <= tmu_pkg::AXIL_IDLE;
			rd_state <= tmu_pkg::AXIL_IDLE;
		end else begin
			if (wr_fire)
				wr_state <= tmu_pkg::AXIL_RESP;
			else if (s_axil_bready_i)
				wr_state <= tmu_pkg::AXIL_IDLE;
			if (rd_fire)
				rd_state <= tmu_pkg::AXIL_RESP;
			else if (s_axil_rready_i)
				rd_state <= tmu_pkg::AXIL_IDLE;
		end
	end

	// ####################
	// Control and interrupt

	assign wr_ctrl  = wr_fire && (s_axil_awaddr_i == `TMU_REG_CTRL);
	assign busy_bit = busy_i | start_req | start_o;   // Covers the start in flight
	assign irq_o    = irq_pending;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			start_req   <= 1'b0;
			start_o     <= 1'b0;
			irq_pending <= 1'b0;
		end else begin
			start_req <= wr_ctrl && s_axil_wdata_i[0] && !busy_bit;
			start_o   <= start_req;                 // Lands after bvalid goes out
			if (done_i)
				irq_pending <= 1'b1;
			else if (wr_ctrl && s_axil_wdata_i[1])
				irq_pending <= 1'b0;             // Write 1 to clear
		end
	end

	// Configuration registers
	always_ff @(posedge sys_clk) begin
		if (wr_fire) begin
			case (s_axil_awaddr_i)
				`TMU_REG_SQUAREH: squareh <= s_axil_wdata_i[`TMU_ROW_W-1:0];
				`TMU_REG_AX:      pa.x <= s_axil_wdata_i[CW-1:0];
				`TMU_REG_AY:      pa.y <= s_axil_wdata_i[CW-1:0];
				`TMU_REG_BX:      pb.x <= s_axil_wdata_i[CW-1:0];
				`TMU_REG_BY:      pb.y <= s_axil_wdata_i[CW-1:0];
				`TMU_REG_CX:      pc.x <= s_axil_wdata_i[CW-1:0];
				`TMU_REG_CY:      pc.y <= s_axil_wdata_i[CW-1:0];
				`TMU_REG_DX:      pd.x <= s_axil_wdata_i[CW-1:0];
				`TMU_REG_DY:      pd.y <= s_axil_wdata_i[CW-1:0];
				default: ;                          // Unmapped addresses are ignored
			endcase
		end
	end

	// Readback with coordinates sign extended
	always_comb begin
		rd_mux = '0;
		case (s_axil_araddr_i)
			`TMU_REG_CTRL: begin
				rd_mux[0] = busy_bit;
				rd_mux[1] = irq_pending;
			end
			`TMU_REG_SQUAREH: rd_mux[`TMU_ROW_W-1:0] = squareh;
			`TMU_REG_AX:      rd_mux = sext(pa.x);
			`TMU_REG_AY:      rd_mux = sext(pa.y);
			`TMU_REG_BX:      rd_mux = sext(pb.x);
			`TMU_REG_BY:      rd_mux = sext(pb.y);
			`TMU_REG_CX:      rd_mux = sext(pc.x);
			`TMU_REG_CY:      rd_mux = sext(pc.y);
			`TMU_REG_DX:      rd_mux = sext(pd.x);
			`TMU_REG_DY:      rd_mux = sext(pd.y);
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (rd_fire)
			s_axil_rdata_o <= rd_mux;
	end

	// Left edge walks A to C, right edge B to D
	always_comb begin
		left_cfg_o.start_pt  = pa;
		left_cfg_o.end_pt    = pc;
		right_cfg_o.start_pt = pb;
		right_cfg_o.end_pt   = pd;
	end

	assign squareh_o = squareh;

endmodule

`default_nettype wire

// File: verilog/tmu_edge_interp.sv
// Edge interpolator with serial quotient/remainder divider and row stepper
`timescale 1ns/1ps
`default_nettype none

`include "tmu_defs.svh"

module tmu_edge_interp (
	input  wire                         sys_clk,
	input  wire                         sys_rst,
	input  wire                         start_i,
	input  wire tmu_pkg::tmu_edge_cfg_t cfg_i,
	input  wire [`TMU_ROW_W-1:0]        squareh_i,
	input  wire                         step_i,
	output tmu_pkg::tmu_point_t         point_o,
	output logic                        valid_o
);

	localparam int CW = `TMU_COORD_W;
	localparam int MW = CW - 1;                     // Magnitude width
	localparam int RW = `TMU_ROW_W;
	localparam int NW = $clog2(`TMU_DIV_STEPS + 1);

	tmu_pkg::edge_state_e state;
	tmu_pkg::tmu_point_t  base;
	logic [NW-1:0]        cnt;
	logic [RW-1:0]        div;                      // Latched squareh
	logic                 neg_x, neg_y;
	logic [MW-1:0]        quo_x, quo_y;             // Dividend, then quotient
	logic [RW-1:0]        rem_x, rem_y;
	logic [CW-1:0]        off_x, off_y;             // Offset magnitude for current row
	logic [RW-1:0]        acc_x, acc_y;             // Remainder accumulator
	logic signed [CW-1:0] diff_x, diff_y;
	logic [MW-1:0]        mag_x, mag_y;
	logic [RW:0]          nx, ny, sx, sy;

	// Subtract d when it fits and flag the fit in the MSB
	function automatic logic [RW:0] cond_sub(input logic [RW:0] v, input logic [RW-1:0] d);
		logic     ge;
		logic [RW:0] r;
		ge = (v >= {1'b0, d});
		r  = ge ? v - {1'b0, d} : v;
		return {ge, r[RW-1:0]};
	endfunction

	assign diff_x = cfg_i.end_pt.x - cfg_i.start_pt.x;   // Wraps in 18 bits
	assign diff_y = cfg_i.end_pt.y - cfg_i.start_pt.y;
	assign mag_x  = diff_x[CW-1] ? MW'(-diff_x) : MW'(diff_x);
	assign mag_y  = diff_y[CW-1] ? MW'(-diff_y) : MW'(diff_y);

	// One restoring division step per axis
	assign nx = cond_sub({rem_x, quo_x[MW-1]}, div);
	assign ny = cond_sub({rem_y, quo_y[MW-1]}, div);

	// Row step carries one extra unit when the remainder sum reaches squareh
	assign sx = cond_sub({1'b0, acc_x} + {1'b0, rem_x}, div);
	assign sy = cond_sub({1'b0, acc_y} + {1'b0, rem_y}, div);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::EDGE_IDLE;
			cnt   <= '0;
		end else if (start_i) begin
			state <= tmu_pkg::EDGE_DIVIDE;
			cnt   <= '0;
		end else if (state == tmu_pkg::EDGE_DIVIDE) begin
			cnt <= cnt + 1'b1;
			if (cnt == NW'(`TMU_DIV_STEPS - 1))
				state <= tmu_pkg::EDGE_STEP;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (start_i) begin
			base  <= cfg_i.start_pt;
			div   <= squareh_i;
			neg_x <= diff_x[CW-1];
			neg_y <= diff_y[CW-1];
			quo_x <= mag_x;
			quo_y <= mag_y;
			rem_x <= '0;
			rem_y <= '0;
			off_x <= '0;
			off_y <= '0;
			acc_x <= '0;
			acc_y <= '0;
		end else if (state == tmu_pkg::EDGE_DIVIDE) begin
			quo_x <= {quo_x[MW-2:0], nx[RW]};
			quo_y <= {quo_y[MW-2:0], ny[RW]};
			rem_x <= nx[RW-1:0];
			rem_y <= ny[RW-1:0];
		end else if (state == tmu_pkg::EDGE_STEP && step_i) begin
			acc_x <= sx[RW-1:0];
			acc_y <= sy[RW-1:0];
			off_x <= off_x + CW'(quo_x) + CW'(sx[RW]);
			off_y <= off_y + CW'(quo_y) + CW'(sy[RW]);
		end
	end

	// Apply the recorded sign to the offset
	always_comb begin
		point_o.x = base.x + (neg_x ? -off_x : off_x);
		point_o.y = base.y + (neg_y ? -off_y : off_y);
	end

	assign valid_o = (state == tmu_pkg::EDGE_STEP);

endmodule

`default_nettype wire

// File: verilog/tmu_span_join.sv
// Span joiner sequencing rows from both edges onto a valid/ready stream
`timescale 1ns/1ps
`default_nettype none

`include "tmu_defs.svh"

module tmu_span_join (
	input  wire                      sys_clk,
	input  wire                      sys_rst,
	input  wire                      start_i,
	input  wire [`TMU_ROW_W-1:0]     squareh_i,
	input  wire tmu_pkg::tmu_point_t left_i,
	input  wire tmu_pkg::tmu_point_t right_i,
	input  wire                      left_valid_i,
	input  wire                      right_valid_i,
	output tmu_pkg::tmu_span_t       span_o,
	output logic                     span_valid_o,
	input  wire                      span_ready_i,
	output logic                     step_o,
	output logic                     busy_o,
	output logic                     done_o
);

	tmu_pkg::join_state_e  state;
	logic [`TMU_ROW_W-1:0] row;
	logic [`TMU_ROW_W-1:0] rows;      // Span count for this run
	logic                  last;

	assign span_valid_o = (state == tmu_pkg::JOIN_RUN);
	assign step_o       = span_valid_o && span_ready_i;   // Advance both edges
	assign busy_o       = (state != tmu_pkg::JOIN_IDLE);
	assign last         = (row == rows - 1'b1);

	// ####################
	// Row sequencer

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state  <= tmu_pkg::JOIN_IDLE;
			row    <= '0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state)
				tmu_pkg::JOIN_IDLE: begin
					if (start_i) begin
						state <= tmu_pkg::JOIN_WAIT;
						row   <= '0;
					end
				end
				tmu_pkg::JOIN_WAIT: begin
					if (left_valid_i && right_valid_i)   // Both divides finished
						state <= tmu_pkg::JOIN_RUN;
				end
				tmu_pkg::JOIN_RUN: begin
					if (step_o) begin
						row <= row + 1'b1;
						if (last) begin
							state  <= tmu_pkg::JOIN_IDLE;
							done_o <= 1'b1;
						end
					end
				end
				default: state <= tmu_pkg::JOIN_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (start_i && state == tmu_pkg::JOIN_IDLE)
			rows <= squareh_i;
	end

	// Edges hold their points until stepped, so the span stays stable
	always_comb begin
		span_o.row = row;
		span_o.ts  = left_i;
		span_o.te  = right_i;
	end

endmodule

`default_nettype wire

// File: verilog/tmu_top.sv
// TMU vertical interpolation top with register slave, two edge interpolators and span joiner
`timescale 1ns/1ps
`default_nettype none

`include "tmu_defs.svh"

module tmu_top (
	input  wire                        sys_clk,
	input  wire                        sys_rst,
	input  wire [`TMU_AXI_ADDR_W-1:0]  s_axil_awaddr_i,
	input  wire                        s_axil_awvalid_i,
	output logic                       s_axil_awready_o,
	input  wire [`TMU_AXI_DATA_W-1:0]  s_axil_wdata_i,
	input  wire                        s_axil_wvalid_i,
	output logic                       s_axil_wready_o,
	output logic [1:0]                 s_axil_bresp_o,
	output logic                       s_axil_bvalid_o,
	input  wire                        s_axil_bready_i,
	input  wire [`TMU_AXI_ADDR_W-1:0]  s_axil_araddr_i,
	input  wire                        s_axil_arvalid_i,
	output logic                       s_axil_arready_o,
	output logic [`TMU_AXI_DATA_W-1:0] s_axil_rdata_o,
	output logic [1:0]                 s_axil_rresp_o,
	output logic                       s_axil_rvalid_o,
	input  wire                        s_axil_rready_i,
	output tmu_pkg::tmu_span_t         span_o,
	output logic                       span_valid_o,
	input  wire                        span_ready_i,
	output logic                       irq_o
);

	logic                   start, busy, done, step;
	tmu_pkg::tmu_edge_cfg_t left_cfg, right_cfg;
	logic [`TMU_ROW_W-1:0]  squareh;
	tmu_pkg::tmu_point_t    left_pt, right_pt;
	logic                   left_valid, right_valid;

	tmu_csr u_csr (
		.sys_clk          (sys_clk),
		.sys_rst          (sys_rst),
		.s_axil_awaddr_i  (s_axil_awaddr_i),
		.s_axil_awvalid_i (s_axil_awvalid_i),
		.s_axil_awready_o (s_axil_awready_o),
		.s_axil_wdata_i   (s_axil_wdata_i),
		.s_axil_wvalid_i  (s_axil_wvalid_i),
		.s_axil_wready_o  (s_axil_wready_o),
		.s_axil_bresp_o   (s_axil_bresp_o),
		.s_axil_bvalid_o  (s_axil_bvalid_o),
		.s_axil_bready_i  (s_axil_bready_i),
		.s_axil_araddr_i  (s_axil_araddr_i),
		.s_axil_arvalid_i (s_axil_arvalid_i),
		.s_axil_arready_o (s_axil_arready_o),
		.s_axil_rdata_o   (s_axil_rdata_o),
		.s_axil_rresp_o   (s_axil_rresp_o),
		.s_axil_rvalid_o  (s_axil_rvalid_o),
		.s_axil_rready_i  (s_axil_rready_i),
		.busy_i           (busy),
		.done_i           (done),
		.start_o          (start),
		.left_cfg_o       (left_cfg),
		.right_cfg_o      (right_cfg),
		.squareh_o        (squareh),
		.irq_o            (irq_o)
	);

	// A toward C
	tmu_edge_interp u_left_edge (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.start_i   (start),
		.cfg_i     (left_cfg),
		.squareh_i (squareh),
		.step_i    (step),
		.point_o   (left_pt),
		.valid_o   (left_valid)
	);

	// B toward D
	tmu_edge_interp u_right_edge (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.start_i   (start),
		.cfg_i     (right_cfg),
		.squareh_i (squareh),
		.step_i    (step),
		.point_o   (right_pt),
		.valid_o   (right_valid)
	);

	tmu_span_join u_span_join (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.start_i       (start),
		.squareh_i     (squareh),
		.left_i        (left_pt),
		.right_i       (right_pt),
		.left_valid_i  (left_valid),
		.right_valid_i (right_valid),
		.span_o        (span_o),
		.span_valid_o  (span_valid_o),
		.span_ready_i  (span_ready_i),
		.step_o        (step),
		.busy_o        (busy),
		.done_o        (done)
	);

endmodule

`default_nettype wire

// File: testbench/tmu_checker.sv
// Bound assertions for reset values, span stability under back-pressure and AXI4-Lite responses
`timescale 1ns/1ps
`default_nettype none

module tmu_checker (
	input wire                     sys_clk,
	input wire                     sys_rst,
	input wire tmu_pkg::tmu_span_t span_i,
	input wire                     span_valid_i,
	input wire                     span_ready_i,
	input wire                     awready_i,
	input wire                     wready_i,
	input wire                     arready_i,
	input wire                     bvalid_i,
	input wire                     bready_i,
	input wire                     rvalid_i,
	input wire                     rready_i,
	input wire                     irq_i
);

	int unsigned fail_cnt = 0;    // Failed assertion count

	// Everything quiet in the cycle after a reset cycle
	reset_quiet: assert property (@(posedge sys_clk)
		sys_rst |=> !(span_valid_i || irq_i || bvalid_i || rvalid_i ||
		              awready_i || wready_i || arready_i))
	else begin
		fail_cnt++;
		$error("Outputs not low after reset");
	end

	// ####################
	// Handshake holding

	span_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		span_valid_i && !span_ready_i |=> span_valid_i && $stable(span_i))
	else begin
		fail_cnt++;
		$error("Span changed or dropped while stalled");
	end

	bvalid_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		bvalid_i && !bready_i |=> bvalid_i)
	else begin
		fail_cnt++;
		$error("Write response dropped before bready");
	end

	rvalid_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		rvalid_i && !rready_i |=> rvalid_i)
	else begin
		fail_cnt++;
		$error("Read data dropped before rready");
	end

endmodule

`default_nettype wire

// File: testbench/tmu_tb.sv
// Testbench with clock, reset, AXI4-Lite driver, span sink, reference model and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "tmu_defs.svh"

module tmu_tb;

	localparam int N_RUNS      = 10;
	localparam int MAX_SQ      = 40;
	localparam int WDOG_CYCLES = (N_RUNS + 1) * MAX_SQ * 8 + 2000;

	logic                       sys_clk, sys_rst;
	logic [`TMU_AXI_ADDR_W-1:0] s_axil_awaddr, s_axil_araddr;
	logic [`TMU_AXI_DATA_W-1:0] s_axil_wdata, s_axil_rdata;
	logic                       s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
	logic [1:0]                 s_axil_bresp, s_axil_rresp;
	logic                       s_axil_bvalid, s_axil_bready;
	logic                       s_axil_arvalid, s_axil_arready;
	logic                       s_axil_rvalid, s_axil_rready;
	tmu_pkg::tmu_span_t         span;
	logic                       span_valid, span_ready, irq;

	// Run configuration seen by the span sink
	tmu_pkg::tmu_point_t run_a, run_b, run_c, run_d;
	int                  run_sq, span_cnt, ready_mode;
	logic [255:0]        ready_pat;    // Random ready bits, drawn once
	logic [7:0]          pat_idx;

	tmu_top u_dut (
		.sys_clk          (sys_clk),
		.sys_rst          (sys_rst),
		.s_axil_awaddr_i  (s_axil_awaddr),
		.s_axil_awvalid_i (s_axil_awvalid),
		.s_axil_awready_o (s_axil_awready),
		.s_axil_wdata_i   (s_axil_wdata),
		.s_axil_wvalid_i  (s_axil_wvalid),
		.s_axil_wready_o  (s_axil_wready),
		.s_axil_bresp_o   (s_axil_bresp),
		.s_axil_bvalid_o  (s_axil_bvalid),
		.s_axil_bready_i  (s_axil_bready),
		.s_axil_araddr_i  (s_axil_araddr),
		.s_axil_arvalid_i (s_axil_arvalid),
		.s_axil_arready_o (s_axil_arready),
		.s_axil_rdata_o   (s_axil_rdata),
		.s_axil_rresp_o   (s_axil_rresp),
		.s_axil_rvalid_o  (s_axil_rvalid),
		.s_axil_rready_i  (s_axil_rready),
		.span_o           (span),
		.span_valid_o     (span_valid),
		.span_ready_i     (span_ready),
		.irq_o            (irq)
	);

	bind tmu_top tmu_checker u_checker (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.span_i       (span_o),
		.span_valid_i (span_valid_o),
		.span_ready_i (span_ready_i),
		.awready_i    (s_axil_awready_o),
		.wready_i     (s_axil_wready_o),
		.arready_i    (s_axil_arready_o),
		.bvalid_i     (s_axil_bvalid_o),
		.bready_i     (s_axil_bready_i),
		.rvalid_i     (s_axil_rvalid_o),
		.rready_i     (s_axil_rready_i),
		.irq_i        (irq_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	// ####################
	// Reporting and reference model

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_val(input string name, input logic [31:0] got,
	                         input logic [31:0] exp);
		assert (got == exp)
		else abort_run($sformatf("Error at %0d ns: %s got 0x%0h, expected 0x%0h",
		                         $time, name, got, exp));
	endtask

	// start + sign(diff) * floor(|diff| * i / n)
	function automatic logic [17:0] ref_coord(input logic signed [17:0] p0,
	                                          input logic signed [17:0] p1,
	                                          input longint i, input longint n);
		longint diff, mag, off;
		diff = longint'(p1) - longint'(p0);
		mag  = (diff < 0) ? -diff : diff;
		off  = (mag * i) / n;
		return 18'((diff < 0) ? longint'(p0) - off : longint'(p0) + off);
	endfunction

	function automatic logic signed [17:0] rand_coord();
		return 18'(int'($urandom_range(0, 131071)) - 65536);    // Keeps |diff| below 2^17
	endfunction

	function automatic tmu_pkg::tmu_point_t rand_point();
		tmu_pkg::tmu_point_t p;
		p.x = rand_coord();
		p.y = rand_coord();
		return p;
	endfunction

	// ####################
	// AXI4-Lite driver

	task automatic axil_write(input logic [`TMU_AXI_ADDR_W-1:0] addr,
	                          input logic [`TMU_AXI_DATA_W-1:0] data);
		int stall;
		stall          = int'($urandom_range(0, 2));    // Cycles with bready held low
		s_axil_awaddr  = addr;
		s_axil_wdata   = data;
		s_axil_awvalid = 1'b1;
		s_axil_wvalid  = 1'b1;
		s_axil_bready  = (stall == 0);
		@(negedge sys_clk);
		while (!(s_axil_awready && s_axil_wready)) @(negedge sys_clk);
		@(posedge sys_clk);
		#1;
		s_axil_awvalid = 1'b0;
		s_axil_wvalid  = 1'b0;
		@(negedge sys_clk);
		while (!s_axil_bvalid) @(negedge sys_clk);
		check_val("s_axil_bresp_o", 32'(s_axil_bresp), 32'h0);
		repeat (stall) begin
			@(posedge sys_clk);
			#1;
		end
		s_axil_bready = 1'b1;
		@(posedge sys_clk);
		#1;
		s_axil_bready = 1'b0;
	endtask

	task automatic axil_read(input logic [`TMU_AXI_ADDR_W-1:0] addr,
	                         output logic [`TMU_AXI_DATA_W-1:0] data);
		int stall;
		stall          = int'($urandom_range(0, 2));    // Cycles with rready held low
		s_axil_araddr  = addr;
		s_axil_arvalid = 1'b1;
		s_axil_rready  = (stall == 0);
		@(negedge sys_clk);
		while (!s_axil_arready) @(negedge sys_clk);
		@(posedge sys_clk);
		#1;
		s_axil_arvalid = 1'b0;
		@(negedge sys_clk);
		while (!s_axil_rvalid) @(negedge sys_clk);
		data = s_axil_rdata;
		check_val("s_axil_rresp_o", 32'(s_axil_rresp), 32'h0);
		repeat (stall) begin
			@(posedge sys_clk);
			#1;
		end
		s_axil_rready = 1'b1;
		@(posedge sys_clk);
		#1;
		s_axil_rready = 1'b0;
	endtask

	task automatic write_coord(input logic [`TMU_AXI_ADDR_W-1:0] addr, input logic [17:0] v);
		axil_write(addr, {{14{v[17]}}, v});
	endtask

	task automatic load_square();
		write_coord(`TMU_REG_AX, run_a.x);
		write_coord(`TMU_REG_AY, run_a.y);
		write_coord(`TMU_REG_BX, run_b.x);
		write_coord(`TMU_REG_BY, run_b.y);
		write_coord(`TMU_REG_CX, run_c.x);
		write_coord(`TMU_REG_CY, run_c.y);
		write_coord(`TMU_REG_DX, run_d.x);
		write_coord(`TMU_REG_DY, run_d.y);
		axil_write(`TMU_REG_SQUAREH, 32'(run_sq));
	endtask

	// ####################
	// Test sequences

	task automatic test_registers();
		logic [31:0] wv, rv, last_dy;
		for (int k = 0; k < 8; k++) begin
			wv = {{14{1'b0}}, 18'(rand_coord())};
			wv = {{14{wv[17]}}, wv[17:0]};
			axil_write(8'(`TMU_REG_AX + 4 * k), wv);
			axil_read(8'(`TMU_REG_AX + 4 * k), rv);
			check_val("coordinate readback", rv, wv);
			last_dy = wv;
		end
		wv = 32'($urandom_range(1, 2047));
		axil_write(`TMU_REG_SQUAREH, wv);
		axil_read(`TMU_REG_SQUAREH, rv);
		check_val("squareh readback", rv, wv);
		axil_write(8'h28, 32'hFFFF_FFFF);     // Unmapped address is dropped
		axil_read(8'h28, rv);
		check_val("unmapped 0x28", rv, 32'h0);
		axil_read(8'h80, rv);
		check_val("unmapped 0x80", rv, 32'h0);
		axil_read(8'hFC, rv);
		check_val("unmapped 0xFC", rv, 32'h0);
		axil_read(`TMU_REG_DY, rv);
		check_val("DY after unmapped write", rv, last_dy);
	endtask

	// Wait for the interrupt, then check idle state and clear it
	task automatic finish_square();
		logic [31:0] rv;
		@(negedge sys_clk);
		while (!irq) @(negedge sys_clk);
		check_val("span count", 32'(span_cnt), 32'(run_sq));
		check_val("span_valid_o", 32'(span_valid), 32'h0);
		@(posedge sys_clk);
		#1;
		axil_read(`TMU_REG_CTRL, rv);
		check_val("ctrl after run", rv, 32'h2);    // Idle, irq pending
		check_val("irq_o", 32'(irq), 32'h1);
		axil_write(`TMU_REG_CTRL, 32'h2);
		@(negedge sys_clk);
		check_val("irq_o after clear", 32'(irq), 32'h0);
		@(posedge sys_clk);
		#1;
	endtask

	task automatic run_square(input int sq, input int mode);
		logic [31:0] rv;
		run_a  = rand_point();
		run_b  = rand_point();
		run_c  = rand_point();
		run_d  = rand_point();
		run_sq = sq;
		load_square();
		span_cnt   = 0;
		ready_mode = mode;
		axil_write(`TMU_REG_CTRL, 32'h1);
		axil_read(`TMU_REG_CTRL, rv);
		check_val("ctrl busy", rv, 32'h1);
		finish_square();
	endtask

	task automatic start_while_busy();
		logic [31:0] rv;
		run_a  = rand_point();
		run_b  = rand_point();
		run_c  = rand_point();
		run_d  = rand_point();
		run_sq = int'($urandom_range(20, MAX_SQ));
		load_square();
		span_cnt   = 0;
		ready_mode = 2;                        // Spans held back so the run stays busy
		axil_write(`TMU_REG_CTRL, 32'h1);
		axil_read(`TMU_REG_CTRL, rv);
		check_val("ctrl busy", rv, 32'h1);
		axil_write(`TMU_REG_SQUAREH, 32'(run_sq / 2 + 1));
		write_coord(`TMU_REG_AX, rand_coord());
		axil_write(`TMU_REG_CTRL, 32'h1);      // Must be ignored
		ready_mode = 1;
		finish_square();
	endtask

	// Span sink with ready drawn from the pattern
	initial begin : span_sink
		tmu_pkg::tmu_span_t s;
		@(negedge sys_rst);
		forever begin
			@(posedge sys_clk);
			#1;
			case (ready_mode)
				0:       span_ready = 1'b1;
				1:       span_ready = ready_pat[pat_idx];
				default: span_ready = 1'b0;
			endcase
			pat_idx = pat_idx + 8'd1;
			@(negedge sys_clk);
			if (span_valid && span_ready) begin
				s = span;
				assert (span_cnt < run_sq)
				else abort_run("More spans arrived than the square height");
				check_val("span_o.row", 32'(s.row), 32'(span_cnt));
				check_val("span_o.ts.x", 32'($unsigned(s.ts.x)),
				          32'(ref_coord(run_a.x, run_c.x, longint'(span_cnt), longint'(run_sq))));
				check_val("span_o.ts.y", 32'($unsigned(s.ts.y)),
				          32'(ref_coord(run_a.y, run_c.y, longint'(span_cnt), longint'(run_sq))));
				check_val("span_o.te.x", 32'($unsigned(s.te.x)),
				          32'(ref_coord(run_b.x, run_d.x, longint'(span_cnt), longint'(run_sq))));
				check_val("span_o.te.y", 32'($unsigned(s.te.y)),
				          32'(ref_coord(run_b.y, run_d.y, longint'(span_cnt), longint'(run_sq))));
				span_cnt++;
			end
		end
	end

	initial begin : watchdog
		repeat (WDOG_CYCLES) @(posedge sys_clk);
		abort_run("Timeout: the run did not finish within the expected number of cycles");
	end

	// Stop at the first failing bound assertion
	initial begin : assert_watch
		wait (u_dut.u_checker.fail_cnt != 0);
		abort_run("A bound assertion failed");
	end

	// ####################
	// Main sequence

	initial begin : main_seq
		int sq;
		logic [31:0] rv;
		void'($urandom(49122));
		sys_rst        = 1'b1;
		s_axil_awaddr  = '0;
		s_axil_awvalid = 1'b0;
		s_axil_wdata   = '0;
		s_axil_wvalid  = 1'b0;
		s_axil_bready  = 1'b0;
		s_axil_araddr  = '0;
		s_axil_arvalid = 1'b0;
		s_axil_rready  = 1'b0;
		span_ready     = 1'b0;
		ready_mode     = 0;
		span_cnt       = 0;
		run_sq         = 1;
		pat_idx        = '0;
		ready_pat      = '0;
		for (int k = 0; k < 8; k++)
			ready_pat = {ready_pat[223:0], $urandom()};
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;
		repeat (2) @(posedge sys_clk);
		#1;

		check_val("span_valid_o", 32'(span_valid), 32'h0);
		check_val("irq_o", 32'(irq), 32'h0);
		check_val("s_axil_bvalid_o", 32'(s_axil_bvalid), 32'h0);
		check_val("s_axil_rvalid_o", 32'(s_axil_rvalid), 32'h0);
		axil_read(`TMU_REG_CTRL, rv);
		check_val("ctrl after reset", rv, 32'h0);

		test_registers();

		// First half with ready held high, second half with back-pressure
		for (int t = 0; t < N_RUNS; t++) begin
			if (t % 5 == 0)
				sq = 1;
			else if (t % 5 == 1)
				sq = MAX_SQ;
			else
				sq = int'($urandom_range(1, MAX_SQ));
			run_square(sq, (t < N_RUNS / 2) ? 0 : 1);
		end

		start_while_busy();

		repeat (4) @(posedge sys_clk);
		if (u_dut.u_checker.fail_cnt == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			abort_run("Bound assertions reported failures");
		end
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+verilog
verilog/tmu_pkg.sv
verilog/tmu_csr.sv
verilog/tmu_edge_interp.sv
verilog/tmu_span_join.sv
verilog/tmu_top.sv
testbench/tmu_checker.sv
testbench/tmu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the TMU testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sources.f --top-module tmu_tb -Mdir obj_dir -o tmu_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/tmu_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "=== PASS ==="; then
	exit 0
fi
exit 1
